/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_processorci_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* ahb_to_wishbone.sv */
`timescale 1ns/1ps
`include "processorci_config.svh"

module ahb_to_wishbone #(
    parameter logic [`PCI_ADDR_WIDTH-1:0] ADDR_LIMIT = `PCI_ADDR_WIDTH'(4 * `PCI_RAM_WORDS)
) (
    input  logic                             sys_clk_i,
    input  logic                             rst_n_i,

    // AHB-Lite slave side
    input  logic [`PCI_ADDR_WIDTH-1:0]       haddr_i,
    input  processorci_pkg::htrans_e         htrans_i,
    input  logic                             hwrite_i,
    input  processorci_pkg::hsize_e          hsize_i,
    input  logic [`PCI_DATA_WIDTH-1:0]       hwdata_i,
    input  logic                             hready_i,
    output logic [`PCI_DATA_WIDTH-1:0]       hrdata_o,
    output logic                             hreadyout_o,
    output logic                             hresp_o,

    // Wishbone classic master side
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [`PCI_ADDR_WIDTH-3:0]       wb_adr_o,
    output logic [`PCI_DATA_WIDTH/8-1:0]     wb_sel_o,
    output logic [`PCI_DATA_WIDTH-1:0]       wb_dat_w_o,
    input  logic [`PCI_DATA_WIDTH-1:0]       wb_dat_r_i,
    input  logic                             wb_ack_i
);

    localparam int SEL_W = `PCI_DATA_WIDTH / 8;

    processorci_pkg::bridge_state_e state_q;
    processorci_pkg::bridge_state_e state_d;

    logic                          accept;
    logic                          in_range;
    logic [SEL_W-1:0]              sel_d;

    // Captured address phase
    logic [`PCI_ADDR_WIDTH-3:0]    adr_q;
    logic                          we_q;
    logic [SEL_W-1:0]              sel_q;
    logic [`PCI_DATA_WIDTH-1:0]    rdata_q;

    // Byte lanes from transfer size and low address bits
    function automatic logic [SEL_W-1:0] lane_select(
        input processorci_pkg::hsize_e size,
        input logic [1:0]              lo
    );
        logic [SEL_W-1:0] sel;
        case (size)
            processorci_pkg::SZ_BYTE: sel = SEL_W'(1) << lo;
            processorci_pkg::SZ_HALF: sel = lo[1] ? 4'b1100 : 4'b0011;
            default:                  sel = '1; // Word or wider
        endcase
        return sel;
    endfunction

    // IDLE and BUSY pass with a zero-wait OKAY
    assign accept   = hready_i && (htrans_i == processorci_pkg::TR_NONSEQ ||
                                   htrans_i == processorci_pkg::TR_SEQ);
    assign in_range = (haddr_i < ADDR_LIMIT);
    assign sel_d    = lane_select(hsize_i, haddr_i[1:0]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            processorci_pkg::ST_IDLE,
            processorci_pkg::ST_ERR2: begin
                if (accept) begin
                    state_d = in_range ? processorci_pkg::ST_WB : processorci_pkg::ST_ERR1;
                end else begin
                    state_d = processorci_pkg::ST_IDLE;
                end
            end
            processorci_pkg::ST_WB: begin
                if (wb_ack_i) begin
                    state_d = processorci_pkg::ST_IDLE; // Data phase ends next cycle
                end
            end
            processorci_pkg::ST_ERR1: state_d = processorci_pkg::ST_ERR2;
            default:                  state_d = processorci_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= processorci_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address phase stage and read data capture
    always_ff @(posedge sys_clk_i) begin
        if (accept) begin
            adr_q <= haddr_i[`PCI_ADDR_WIDTH-1:2];
            we_q  <= hwrite_i;
            sel_q <= sel_d;
        end
        if (state_q == processorci_pkg::ST_WB && wb_ack_i) begin
            rdata_q <= wb_dat_r_i;
        end
    end

    // Bus-cycle stage
    assign wb_cyc_o   = (state_q == processorci_pkg::ST_WB);
    assign wb_stb_o   = (state_q == processorci_pkg::ST_WB);
    assign wb_we_o    = we_q;
    assign wb_adr_o   = adr_q;
    assign wb_sel_o   = sel_q;
    assign wb_dat_w_o = hwdata_i; // HWDATA valid for the whole data phase

    assign hrdata_o    = rdata_q;
    assign hreadyout_o = (state_q != processorci_pkg::ST_WB) &&
                         (state_q != processorci_pkg::ST_ERR1);
    assign hresp_o     = (state_q == processorci_pkg::ST_ERR1) ||
                         (state_q == processorci_pkg::ST_ERR2);

endmodule

/* flist.f */
+incdir+.
processorci_pkg.sv
ahb_to_wishbone.sv
wb_dual_ram.sv
processorci_top.sv
tb_processorci_top.sv

/* processorci_config.svh */
`ifndef PROCESSORCI_CONFIG_SVH
`define PROCESSORCI_CONFIG_SVH

// Bus widths
`define PCI_ADDR_WIDTH 32
`define PCI_DATA_WIDTH 32

// Shared RAM depth in words
`define PCI_RAM_WORDS 1024

// Extra cycles before the RAM acks
`define PCI_RAM_WAIT 1

`endif

/* processorci_pkg.sv */
package processorci_pkg;

    // AHB-Lite transfer type
    typedef enum logic [1:0] {
        TR_IDLE   = 2'b00,
        TR_BUSY   = 2'b01,
        TR_NONSEQ = 2'b10,
        TR_SEQ    = 2'b11
    } htrans_e;

    // AHB-Lite transfer size, nothing wider than a word
    typedef enum logic [2:0] {
        SZ_BYTE = 3'b000,
        SZ_HALF = 3'b001,
        SZ_WORD = 3'b010
    } hsize_e;

    // Bridge sequencing
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0, // Ready, last data phase done
        ST_WB    = 3'd1, // Wishbone cycle in flight
        ST_ERR1  = 3'd2, // First ERROR cycle
        ST_ERR2  = 3'd3  // Second ERROR cycle
    } bridge_state_e;

endpackage

/* processorci_top.sv */
`timescale 1ns/1ps
`include "processorci_config.svh"

module processorci_top (
    input  logic                           sys_clk_i,
    input  logic                           rst_n_i,

    // AHB instruction bus
    input  logic [`PCI_ADDR_WIDTH-1:0]     imem_haddr_i,
    input  processorci_pkg::htrans_e       imem_htrans_i,
    input  logic                           imem_hwrite_i,
    input  processorci_pkg::hsize_e        imem_hsize_i,
    input  logic [`PCI_DATA_WIDTH-1:0]     imem_hwdata_i,
    output logic [`PCI_DATA_WIDTH-1:0]     imem_hrdata_o,
    output logic                           imem_hreadyout_o,
    output logic                           imem_hresp_o,

    // AHB data bus
    input  logic [`PCI_ADDR_WIDTH-1:0]     dmem_haddr_i,
    input  processorci_pkg::htrans_e       dmem_htrans_i,
    input  logic                           dmem_hwrite_i,
    input  processorci_pkg::hsize_e        dmem_hsize_i,
    input  logic [`PCI_DATA_WIDTH-1:0]     dmem_hwdata_i,
    output logic [`PCI_DATA_WIDTH-1:0]     dmem_hrdata_o,
    output logic                           dmem_hreadyout_o,
    output logic                           dmem_hresp_o
);

    localparam logic [`PCI_ADDR_WIDTH-1:0] RAM_BYTES = `PCI_ADDR_WIDTH'(4 * `PCI_RAM_WORDS);

    // Wishbone, instruction side
    logic                         iwb_cyc;
    logic                         iwb_stb;
    logic                         iwb_we;
    logic [`PCI_ADDR_WIDTH-3:0]   iwb_adr;
    logic [`PCI_DATA_WIDTH/8-1:0] iwb_sel;
    logic [`PCI_DATA_WIDTH-1:0]   iwb_dat_w;
    logic [`PCI_DATA_WIDTH-1:0]   iwb_dat_r;
    logic                         iwb_ack;

    // Wishbone, data side
    logic                         dwb_cyc;
    logic                         dwb_stb;
    logic                         dwb_we;
    logic [`PCI_ADDR_WIDTH-3:0]   dwb_adr;
    logic [`PCI_DATA_WIDTH/8-1:0] dwb_sel;
    logic [`PCI_DATA_WIDTH-1:0]   dwb_dat_w;
    logic [`PCI_DATA_WIDTH-1:0]   dwb_dat_r;
    logic                         dwb_ack;

    ahb_to_wishbone #(.ADDR_LIMIT(RAM_BYTES)) u_imem_bridge (
        .sys_clk_i   (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .haddr_i     (imem_haddr_i),
        .htrans_i    (imem_htrans_i),
        .hwrite_i    (imem_hwrite_i),
        .hsize_i     (imem_hsize_i),
        .hwdata_i    (imem_hwdata_i),
        .hready_i    (imem_hreadyout_o), // Sole slave on this bus
        .hrdata_o    (imem_hrdata_o),
        .hreadyout_o (imem_hreadyout_o),
        .hresp_o     (imem_hresp_o),
        .wb_cyc_o    (iwb_cyc),
        .wb_stb_o    (iwb_stb),
        .wb_we_o     (iwb_we),
        .wb_adr_o    (iwb_adr),
        .wb_sel_o    (iwb_sel),
        .wb_dat_w_o  (iwb_dat_w),
        .wb_dat_r_i  (iwb_dat_r),
        .wb_ack_i    (iwb_ack)
    );

    ahb_to_wishbone #(.ADDR_LIMIT(RAM_BYTES)) u_dmem_bridge (
        .sys_clk_i   (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .haddr_i     (dmem_haddr_i),
        .htrans_i    (dmem_htrans_i),
        .hwrite_i    (dmem_hwrite_i),
        .hsize_i     (dmem_hsize_i),
        .hwdata_i    (dmem_hwdata_i),
        .hready_i    (dmem_hreadyout_o),
        .hrdata_o    (dmem_hrdata_o),
        .hreadyout_o (dmem_hreadyout_o),
        .hresp_o     (dmem_hresp_o),
        .wb_cyc_o    (dwb_cyc),
        .wb_stb_o    (dwb_stb),
        .wb_we_o     (dwb_we),
        .wb_adr_o    (dwb_adr),
        .wb_sel_o    (dwb_sel),
        .wb_dat_w_o  (dwb_dat_w),
        .wb_dat_r_i  (dwb_dat_r),
        .wb_ack_i    (dwb_ack)
    );

    wb_dual_ram #(
        .WORDS       (`PCI_RAM_WORDS),
        .WAIT_STATES (`PCI_RAM_WAIT)
    ) u_ram (
        .sys_clk_i   (sys_clk_i),
        .rst_n_i     (rst_n_i),
        .i_cyc_i     (iwb_cyc),
        .i_stb_i     (iwb_stb),
        .i_we_i      (iwb_we),
        .i_adr_i     (iwb_adr),
        .i_sel_i     (iwb_sel),
        .i_dat_w_i   (iwb_dat_w),
        .i_dat_r_o   (iwb_dat_r),
        .i_ack_o     (iwb_ack),
        .d_cyc_i     (dwb_cyc),
        .d_stb_i     (dwb_stb),
        .d_we_i      (dwb_we),
        .d_adr_i     (dwb_adr),
        .d_sel_i     (dwb_sel),
        .d_dat_w_i   (dwb_dat_w),
        .d_dat_r_o   (dwb_dat_r),
        .d_ack_o     (dwb_ack)
    );

endmodule

/* tb_processorci_top.sv */
`timescale 1ns/1ps
`include "processorci_config.svh"

module tb_processorci_top;

    localparam int          IDX_W     = $clog2(`PCI_RAM_WORDS);
    localparam logic [31:0] RAM_BYTES = 32'(4 * `PCI_RAM_WORDS);
    localparam int          N_XFER    = 76; // 32 + 16 + 8 + 4 + 16 transfers
    localparam int          TIMEOUT   = N_XFER * (`PCI_RAM_WAIT + 4) + 200;

    logic                       clk;
    logic                       rst_n;
    logic [`PCI_ADDR_WIDTH-1:0] haddr     [2]; // Index 0 is imem, 1 is dmem
    processorci_pkg::htrans_e   htrans    [2];
    logic                       hwrite    [2];
    processorci_pkg::hsize_e    hsize     [2];
    logic [`PCI_DATA_WIDTH-1:0] hwdata    [2];
    logic [`PCI_DATA_WIDTH-1:0] hrdata    [2];
    logic                       hreadyout [2];
    logic                       hresp     [2];

    logic [31:0] shadow   [`PCI_RAM_WORDS];
    logic        pend_v   [2]; // Data phase outstanding
    logic        pend_rd  [2];
    logic        pend_err [2];
    logic [31:0] pend_exp [2];
    logic [31:0] addrs    [16];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;

    processorci_top i_dut (
        .sys_clk_i        (clk),
        .rst_n_i          (rst_n),
        .imem_haddr_i     (haddr[0]),
        .imem_htrans_i    (htrans[0]),
        .imem_hwrite_i    (hwrite[0]),
        .imem_hsize_i     (hsize[0]),
        .imem_hwdata_i    (hwdata[0]),
        .imem_hrdata_o    (hrdata[0]),
        .imem_hreadyout_o (hreadyout[0]),
        .imem_hresp_o     (hresp[0]),
        .dmem_haddr_i     (haddr[1]),
        .dmem_htrans_i    (htrans[1]),
        .dmem_hwrite_i    (hwrite[1]),
        .dmem_hsize_i     (hsize[1]),
        .dmem_hwdata_i    (hwdata[1]),
        .dmem_hrdata_o    (hrdata[1]),
        .dmem_hreadyout_o (hreadyout[1]),
        .dmem_hresp_o     (hresp[1])
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic string port_name(input int p);
        return (p == 0) ? "imem" : "dmem";
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Runs until the final data-phase cycle and checks the response there
    task automatic finish_phase(input int p);
        int low;
        low = 0;
        while (!hreadyout[p]) begin
            if (pend_v[p]) begin
                compare_value({port_name(p), "_hresp_o"}, 32'(pend_err[p]), 32'(hresp[p]));
            end
            low++;
            next_cycle();
        end
        if (pend_v[p]) begin
            compare_value({port_name(p), "_hreadyout_o low cycles"},
                          pend_err[p] ? 1 : `PCI_RAM_WAIT + 2, low);
            compare_value({port_name(p), "_hresp_o"}, 32'(pend_err[p]), 32'(hresp[p]));
            if (pend_rd[p] && !pend_err[p]) begin
                compare_value({port_name(p), "_hrdata_o"}, pend_exp[p], hrdata[p]);
            end
            pend_v[p] = 1'b0;
        end
    endtask

    // Address phase goes out in the last cycle of the previous data phase
    task automatic ahb_issue(input int p, input logic write, input processorci_pkg::hsize_e size,
                             input logic [31:0] addr, input logic [31:0] wdata);
        logic [IDX_W-1:0] idx;
        logic             lane_hit;
        idx = addr[IDX_W+1:2];
        finish_phase(p);
        haddr[p]  = addr;
        htrans[p] = processorci_pkg::TR_NONSEQ;
        hwrite[p] = write;
        hsize[p]  = size;
        next_cycle();
        htrans[p]   = processorci_pkg::TR_IDLE;
        hwdata[p]   = wdata;
        pend_v[p]   = 1'b1;
        pend_err[p] = (addr >= RAM_BYTES);
        pend_rd[p]  = !write;
        if (write && !pend_err[p]) begin
            for (int b = 0; b < 4; b++) begin
                lane_hit = (size == processorci_pkg::SZ_WORD) ||
                           (size == processorci_pkg::SZ_HALF && b[1] == addr[1]) ||
                           (size == processorci_pkg::SZ_BYTE && b[1:0] == addr[1:0]);
                if (lane_hit) shadow[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        pend_exp[p] = shadow[idx];
    endtask

    task automatic transfer(input int p, input logic write, input processorci_pkg::hsize_e size,
                            input logic [31:0] addr, input logic [31:0] wdata);
        ahb_issue(p, write, size, addr, wdata);
        finish_phase(p);
        next_cycle(); // Idle gap
    endtask

    for (genvar p = 0; p < 2; p++) begin : g_err_resp
        assert property (@(posedge clk) disable iff (!rst_n)
            (hresp[p] && !hreadyout[p]) |=> (hresp[p] && hreadyout[p]))
        else begin
            errors++;
            $display("ERROR response on port %0d was not followed by its ready cycle", p);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        i_dut.dwb_ack |-> (i_dut.dwb_cyc && i_dut.dwb_stb))
    else begin
        errors++;
        $display("Data port RAM acknowledged without an active strobe");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        i_dut.iwb_ack |-> (i_dut.iwb_cyc && i_dut.iwb_stb))
    else begin
        errors++;
        $display("Instruction port RAM acknowledged without an active strobe");
    end

    assert property (@(posedge clk) disable iff (!rst_n) hresp[1] |-> !i_dut.dwb_cyc)
    else begin
        errors++;
        $display("Data bridge started a Wishbone cycle for an out-of-range address");
    end

    initial begin
        logic [1:0]              off;
        processorci_pkg::hsize_e sz;
        clk    = 1'b0;
        rst_n  = 1'b0;
        lfsr   = 32'hfa85;
        errors = 0;
        checks = 0;
        cycles = 0;
        for (int p = 0; p < 2; p++) begin
            haddr[p]  = '0;
            htrans[p] = processorci_pkg::TR_IDLE;
            hwrite[p] = 1'b0;
            hsize[p]  = processorci_pkg::SZ_WORD;
            hwdata[p] = '0;
            pend_v[p] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        // Reset values, then IDLE and BUSY get OKAY with no wait
        for (int i = 0; i < 5; i++) begin
            for (int p = 0; p < 2; p++) begin
                compare_value({port_name(p), "_hreadyout_o"}, 1, 32'(hreadyout[p]));
                compare_value({port_name(p), "_hresp_o"}, 0, 32'(hresp[p]));
                htrans[p] = (i % 2 == 1) ? processorci_pkg::TR_BUSY : processorci_pkg::TR_IDLE;
            end
            next_cycle();
        end

        for (int i = 0; i < 16; i++) begin
            addrs[i] = rand_bits(IDX_W) << 2;
            transfer(1, 1'b1, processorci_pkg::SZ_WORD, addrs[i], rand_bits(32));
        end
        for (int i = 0; i < 16; i++) transfer(1, 1'b0, processorci_pkg::SZ_WORD, addrs[i], '0);

        // Sub-word writes merged into earlier words
        for (int i = 0; i < 8; i++) begin
            sz  = rand_bits(1) ? processorci_pkg::SZ_HALF : processorci_pkg::SZ_BYTE;
            off = 2'(rand_bits(2));
            if (sz == processorci_pkg::SZ_HALF) off[0] = 1'b0;
            transfer(1, 1'b1, sz, addrs[i] | 32'(off), rand_bits(32));
            transfer(1, 1'b0, processorci_pkg::SZ_WORD, addrs[i], '0);
        end

        // Written by dmem, read by imem
        for (int i = 0; i < 4; i++) begin
            addrs[i] = rand_bits(IDX_W) << 2;
            transfer(1, 1'b1, processorci_pkg::SZ_WORD, addrs[i], rand_bits(32));
            transfer(0, 1'b0, processorci_pkg::SZ_WORD, addrs[i], '0);
        end

        transfer(1, 1'b1, processorci_pkg::SZ_WORD, RAM_BYTES + addrs[0], rand_bits(32));
        transfer(1, 1'b0, processorci_pkg::SZ_WORD, RAM_BYTES, '0);
        transfer(1, 1'b0, processorci_pkg::SZ_WORD, addrs[0], '0); // Alias untouched
        transfer(0, 1'b0, processorci_pkg::SZ_WORD, RAM_BYTES + addrs[1], '0);

        for (int i = 0; i < 8; i++) begin
            addrs[i] = rand_bits(IDX_W) << 2;
            ahb_issue(1, 1'b1, processorci_pkg::SZ_WORD, addrs[i], rand_bits(32));
        end
        for (int i = 0; i < 8; i++) ahb_issue(1, 1'b0, processorci_pkg::SZ_WORD, addrs[i], '0);
        finish_phase(1);
        next_cycle();

        $display("Summary: %0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* wb_dual_ram.sv */
`timescale 1ns/1ps
`include "processorci_config.svh"

module wb_dual_ram #(
    parameter int WORDS       = `PCI_RAM_WORDS,
    parameter int WAIT_STATES = `PCI_RAM_WAIT
) (
    input  logic                         sys_clk_i,
    input  logic                         rst_n_i,

    // Instruction port
    input  logic                         i_cyc_i,
    input  logic                         i_stb_i,
    input  logic                         i_we_i,
    input  logic [`PCI_ADDR_WIDTH-3:0]   i_adr_i,
    input  logic [`PCI_DATA_WIDTH/8-1:0] i_sel_i,
    input  logic [`PCI_DATA_WIDTH-1:0]   i_dat_w_i,
    output logic [`PCI_DATA_WIDTH-1:0]   i_dat_r_o,
    output logic                         i_ack_o,

    // Data port
    input  logic                         d_cyc_i,
    input  logic                         d_stb_i,
    input  logic                         d_we_i,
    input  logic [`PCI_ADDR_WIDTH-3:0]   d_adr_i,
    input  logic [`PCI_DATA_WIDTH/8-1:0] d_sel_i,
    input  logic [`PCI_DATA_WIDTH-1:0]   d_dat_w_i,
    output logic [`PCI_DATA_WIDTH-1:0]   d_dat_r_o,
    output logic                         d_ack_o
);

    localparam int DW    = `PCI_DATA_WIDTH;
    localparam int SW    = DW / 8;
    localparam int IDX_W = $clog2(WORDS);
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_STATES);

    logic [DW-1:0] mem [WORDS];

    // Index 0 is the instruction port, 1 the data port
    logic [1:0]              req;
    logic [1:0]              we;
    logic [1:0][IDX_W-1:0]   idx;
    logic [1:0][SW-1:0]      sel;
    logic [1:0][DW-1:0]      dat_w;
    logic                    fire    [2];
    logic                    ack_q   [2];
    logic [CNT_W-1:0]        cnt_q   [2];
    logic [DW-1:0]           dat_r_q [2];

    assign req   = {d_cyc_i & d_stb_i, i_cyc_i & i_stb_i};
    assign we    = {d_we_i, i_we_i};
    assign idx   = {d_adr_i[IDX_W-1:0], i_adr_i[IDX_W-1:0]}; // No range check here
    assign sel   = {d_sel_i, i_sel_i};
    assign dat_w = {d_dat_w_i, i_dat_w_i};

    for (genvar p = 0; p < 2; p++) begin : g_port
        // Access happens on the cycle the ack is raised
        assign fire[p] = req[p] & ~ack_q[p] & (cnt_q[p] == CNT_LAST);

        always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                cnt_q[p] <= '0;
                ack_q[p] <= 1'b0;
            end else if (ack_q[p] || !req[p]) begin
                cnt_q[p] <= '0;
                ack_q[p] <= 1'b0; // One ack per strobe
            end else if (cnt_q[p] == CNT_LAST) begin
                ack_q[p] <= 1'b1;
            end else begin
                cnt_q[p] <= cnt_q[p] + 1'b1;
            end
        end

        always_ff @(posedge sys_clk_i) begin
            if (fire[p]) begin
                dat_r_q[p] <= mem[idx[p]];
            end
        end
    end

    // Data port is applied last and wins a same-word collision
    always_ff @(posedge sys_clk_i) begin
        for (int p = 0; p < 2; p++) begin
            if (fire[p] && we[p]) begin
                for (int b = 0; b < SW; b++) begin
                    if (sel[p][b]) mem[idx[p]][8*b +: 8] <= dat_w[p][8*b +: 8];
                end
            end
        end
    end

    assign i_dat_r_o = dat_r_q[0];
    assign i_ack_o   = ack_q[0];
    assign d_dat_r_o = dat_r_q[1];
    assign d_ack_o   = ack_q[1];

endmodule
